// ==== hdl/sms_defines.svh ====
`ifndef SMS_DEFINES_SVH
`define SMS_DEFINES_SVH

// ========================================
// I/O ports, matched on A7..A0
// ========================================
`define SMS_VDP_DATA_PORT   8'hBE
`define SMS_VDP_CTRL_PORT   8'hBF
`define SMS_PSG_PORT        8'h7F  // Write side of 7F
`define SMS_V_COUNTER_PORT  8'h7E
`define SMS_H_COUNTER_PORT  8'h7F  // Read side of 7F
`define SMS_JOY_PORT_0      8'hDC
`define SMS_JOY_PORT_1      8'hDD
`define SMS_JOY_PORT_2      8'hDE
`define SMS_MEM_CTRL_PORT   8'h3E

// Mapper slot registers at the top of RAM
`define SMS_SLOT0_ADDR      16'hFFFD
`define SMS_SLOT1_ADDR      16'hFFFE
`define SMS_SLOT2_ADDR      16'hFFFF

`define SMS_MEM_CTRL_RESET  8'hF7  // Bit 3 low, BIOS enabled

// ========================================
// Sizes
// ========================================
`define SMS_NUM_VDP_REGS    11
`define SMS_VRAM_ADDR_W     14
`define SMS_ROM_ADDR_W      22
`define SMS_CPU_DIV         7      // Clock enable period in cycles

`endif

// ==== hdl/sms_pkg.sv ====
`default_nettype none

package sms_pkg;

  // Second control byte when it carries an address
  typedef struct packed {
    logic [1:0] code;     // 0,1 VRAM; 3 CRAM
    logic [5:0] addr_hi;  // A13..A8
  } vdp_addr_view_t;

  // Second control byte when it targets a register
  typedef struct packed {
    logic [1:0] code;     // 2 for a register write
    logic [1:0] unused;
    logic [3:0] index;
  } vdp_reg_view_t;

  // One byte from the CPU, read whichever way the command needs
  typedef union packed {
    logic [7:0]     raw;
    vdp_addr_view_t addr;
    vdp_reg_view_t  regs;
  } vdp_ctrl_word_t;

endpackage

`default_nettype wire

// ==== hdl/bus_cycle_decode.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "sms_defines.svh"

module bus_cycle_decode
  import sms_pkg::*;
(
  input  logic           cpuClock,
  input  logic           n_hard_reset,
  input  logic           i_n_rd,
  input  logic           i_n_wr,
  input  logic           i_n_mreq,
  input  logic           i_n_iorq,
  input  logic [15:0]    i_cpu_address,
  input  logic [7:0]     i_cpu_data_out,
  output logic           o_cpu_clock_enable,
  output logic           o_bus_edge,
  output logic           o_vdp_ctrl_wr,
  output logic           o_vdp_data_wr,
  output logic           o_mem_ctrl_wr,
  output logic           o_psg_wr,
  output logic           o_slot_wr,
  output logic [1:0]     o_slot_sel,
  output vdp_ctrl_word_t o_wr_data,
  output logic           o_vdp_data_rd,
  output logic           o_vdp_ctrl_rd
);

  logic [2:0] div_count;
  logic       enable_q;
  logic       io_wr;
  logic       io_rd;
  logic       mem_wr;
  logic [7:0] port;
  logic       slot_hit;
  logic [1:0] slot_idx;

  // ========================================
  // CPU clock enable
  // ========================================
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      div_count <= '0;
      enable_q  <= 1'b0;
    end else begin
      enable_q <= o_cpu_clock_enable;
      if (div_count == 3'(`SMS_CPU_DIV - 1))
        div_count <= '0;
      else
        div_count <= div_count + 3'd1;
    end
  end

  assign o_cpu_clock_enable = div_count[2];  // Counts 4 to 6
  assign o_bus_edge         = o_cpu_clock_enable && !enable_q;

  // Z80 strobes merged into requests
  assign io_wr  = !i_n_iorq && !i_n_wr;
  assign io_rd  = !i_n_iorq && !i_n_rd;
  assign mem_wr = !i_n_mreq && !i_n_wr;
  assign port   = i_cpu_address[7:0];

  assign o_vdp_data_rd = io_rd && (port == `SMS_VDP_DATA_PORT);
  assign o_vdp_ctrl_rd = io_rd && (port == `SMS_VDP_CTRL_PORT);

  always_comb begin
    slot_hit = mem_wr;
    case (i_cpu_address)
      `SMS_SLOT0_ADDR: slot_idx = 2'd0;
      `SMS_SLOT1_ADDR: slot_idx = 2'd1;
      `SMS_SLOT2_ADDR: slot_idx = 2'd2;
      default: begin
        slot_idx = 2'd3;
        slot_hit = 1'b0;
      end
    endcase
  end

  // ========================================
  // Write request stage
  // ========================================
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      o_vdp_ctrl_wr <= 1'b0;
      o_vdp_data_wr <= 1'b0;
      o_mem_ctrl_wr <= 1'b0;
      o_psg_wr      <= 1'b0;
      o_slot_wr     <= 1'b0;
    end else begin
      // One cycle pulses, the cycle after the edge
      o_vdp_ctrl_wr <= o_bus_edge && io_wr && (port == `SMS_VDP_CTRL_PORT);
      o_vdp_data_wr <= o_bus_edge && io_wr && (port == `SMS_VDP_DATA_PORT);
      o_mem_ctrl_wr <= o_bus_edge && io_wr && (port == `SMS_MEM_CTRL_PORT);
      o_psg_wr      <= o_bus_edge && io_wr && (port == `SMS_PSG_PORT);
      o_slot_wr     <= o_bus_edge && slot_hit;
    end
  end

  always_ff @(posedge cpuClock) begin
    if (o_bus_edge) begin
      o_slot_sel    <= slot_idx;
      o_wr_data.raw <= i_cpu_data_out;  // Byte rides with the request
    end
  end

endmodule

`default_nettype wire

// ==== hdl/vdp_port.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "sms_defines.svh"

module vdp_port
  import sms_pkg::*;
(
  input  logic                        cpuClock,
  input  logic                        n_hard_reset,
  input  logic                        i_vdp_ctrl_wr,
  input  logic                        i_vdp_data_wr,
  input  logic                        i_vdp_data_rd,
  input  logic                        i_vdp_ctrl_rd,
  input  logic                        i_bus_edge,
  input  vdp_ctrl_word_t              i_wr_data,
  output logic [`SMS_VRAM_ADDR_W-1:0] o_vram_addr,
  output logic                        o_cram_selected,
  output logic                        o_vram_wr,
  output logic                        o_vram_rd,
  output logic [2:0]                  o_mode,
  output logic [`SMS_VRAM_ADDR_W-1:0] o_name_table_addr,
  output logic                        o_video_on,
  output logic                        o_vert_retrace_int
);

  logic [7:0] vdp_regs [`SMS_NUM_VDP_REGS];
  logic       second_byte;  // Next control byte completes a command
  logic [7:0] first_byte;
  logic       data_rd_q;
  logic       reg_write;

  assign reg_write = (i_wr_data.regs.code == 2'd2) &&
                     (i_wr_data.regs.index < 4'(`SMS_NUM_VDP_REGS));

  // ========================================
  // Control port and address pointer
  // ========================================
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      second_byte     <= 1'b0;
      data_rd_q       <= 1'b0;
      o_vram_addr     <= '0;
      o_cram_selected <= 1'b0;
    end else begin
      if (i_bus_edge) begin
        data_rd_q <= i_vdp_data_rd;
        // Step past the byte once the read has finished
        if (data_rd_q && !i_vdp_data_rd)
          o_vram_addr <= o_vram_addr + 1'b1;
        if (i_vdp_data_rd || i_vdp_ctrl_rd)
          second_byte <= 1'b0;
      end
      if (i_vdp_data_wr) begin
        o_vram_addr <= o_vram_addr + 1'b1;
        second_byte <= 1'b0;
      end
      if (i_vdp_ctrl_wr) begin
        second_byte <= !second_byte;
        if (second_byte && !reg_write) begin
          if (i_wr_data.addr.code[1]) begin
            // Code 3, or a register index out of range
            o_vram_addr     <= {{(`SMS_VRAM_ADDR_W - 6){1'b0}}, first_byte[5:0]};
            o_cram_selected <= 1'b1;
          end else begin
            o_vram_addr     <= {i_wr_data.addr.addr_hi, first_byte};
            o_cram_selected <= 1'b0;
          end
        end
      end
    end
  end

  always_ff @(posedge cpuClock) begin
    if (i_vdp_ctrl_wr && !second_byte)
      first_byte <= i_wr_data.raw;
  end

  // ========================================
  // Register file
  // ========================================
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      for (int i = 0; i < `SMS_NUM_VDP_REGS; i++) begin
        vdp_regs[i] <= 8'h00;
      end
    end else if (i_vdp_ctrl_wr && second_byte && reg_write) begin
      vdp_regs[i_wr_data.regs.index] <= first_byte;
    end
  end

  // Mode select, M4 wins over M3, M2 and M1
  always_comb begin
    if (vdp_regs[0][2])
      o_mode = 3'd4;
    else if (vdp_regs[1][3])
      o_mode = 3'd3;
    else if (vdp_regs[0][1])
      o_mode = 3'd2;
    else if (vdp_regs[1][4])
      o_mode = 3'd1;
    else
      o_mode = 3'd0;
  end

  assign o_name_table_addr  = {vdp_regs[2][3:1], 11'b0};
  assign o_video_on         = vdp_regs[1][6];
  assign o_vert_retrace_int = vdp_regs[1][5];

  assign o_vram_wr = i_vdp_data_wr;              // Address is still the old one
  assign o_vram_rd = i_bus_edge && i_vdp_data_rd;

endmodule

`default_nettype wire

// ==== hdl/memory_mapper.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "sms_defines.svh"

module memory_mapper
  import sms_pkg::*;
(
  input  logic                       cpuClock,
  input  logic                       n_hard_reset,
  input  logic                       i_slot_wr,
  input  logic [1:0]                 i_slot_sel,
  input  logic                       i_mem_ctrl_wr,
  input  vdp_ctrl_word_t             i_wr_data,
  input  logic [15:0]                i_cpu_address,
  output logic [`SMS_ROM_ADDR_W-1:0] o_rom_address,
  output logic                       o_bios_selected
);

  logic [7:0] slot0;
  logic [7:0] slot1;
  logic [7:0] slot2;
  logic [7:0] mem_ctrl;

  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      slot0    <= 8'd0;
      slot1    <= 8'd1;
      slot2    <= 8'd2;
      mem_ctrl <= `SMS_MEM_CTRL_RESET;
    end else begin
      if (i_slot_wr) begin
        case (i_slot_sel)
          2'd0:    slot0 <= i_wr_data.raw;
          2'd1:    slot1 <= i_wr_data.raw;
          2'd2:    slot2 <= i_wr_data.raw;
          default: ;
        endcase
      end
      if (i_mem_ctrl_wr)
        mem_ctrl <= i_wr_data.raw;
    end
  end

  // Bank number on top of the 16K offset
  always_comb begin
    case (i_cpu_address[15:14])
      2'd0:    o_rom_address = {slot0, i_cpu_address[13:0]};
      2'd1:    o_rom_address = {slot1, i_cpu_address[13:0]};
      2'd2:    o_rom_address = {slot2, i_cpu_address[13:0]};
      default: o_rom_address = {{(`SMS_ROM_ADDR_W - 16){1'b0}}, i_cpu_address};
    endcase
  end

  assign o_bios_selected = !mem_ctrl[3];

endmodule

`default_nettype wire

// ==== hdl/cpu_read_mux.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "sms_defines.svh"

module cpu_read_mux (
  input  logic        cpuClock,
  input  logic        n_hard_reset,
  input  logic        i_n_rd,
  input  logic        i_n_mreq,
  input  logic        i_n_iorq,
  input  logic [15:0] i_cpu_address,
  input  logic        i_bus_edge,
  input  logic        i_vdp_ctrl_rd,
  input  logic        i_vdp_data_rd,
  input  logic        i_bios_selected,
  input  logic [7:0]  i_vdp_data,
  input  logic [7:0]  i_v_counter,
  input  logic [7:0]  i_h_counter,
  input  logic [6:0]  i_buttons,
  input  logic        i_interrupt_flag,
  input  logic        i_sprite_collision,
  input  logic        i_too_many_sprites,
  input  logic [4:0]  i_sprite5,
  input  logic [7:0]  i_ram_data,
  input  logic [7:0]  i_bios_data,
  input  logic [7:0]  i_rom_data,
  output logic [7:0]  o_cpu_data_in
);

  logic       int_flag_q;
  logic       collision_q;
  logic       status_rd_q;
  logic [7:0] status;
  logic [7:0] joy_data;
  logic       io_rd;
  logic       mem_rd;
  logic [7:0] port;

  // ========================================
  // Sticky status flags
  // ========================================
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      int_flag_q  <= 1'b0;
      collision_q <= 1'b0;
      status_rd_q <= 1'b0;
    end else begin
      if (i_interrupt_flag)
        int_flag_q <= 1'b1;
      if (i_sprite_collision)
        collision_q <= 1'b1;
      if (i_bus_edge) begin
        status_rd_q <= i_vdp_ctrl_rd;
        if (status_rd_q && !i_vdp_ctrl_rd) begin  // Read has ended
          int_flag_q  <= 1'b0;
          collision_q <= 1'b0;
        end
      end
    end
  end

  assign status   = {int_flag_q, i_too_many_sprites, collision_q,
                     i_too_many_sprites ? i_sprite5 : 5'h1F};
  assign joy_data = {2'b00, ~i_buttons[2:1], ~i_buttons[6:3]};  // Active low pad

  assign io_rd  = !i_n_iorq && !i_n_rd;
  assign mem_rd = !i_n_mreq && !i_n_rd;
  assign port   = i_cpu_address[7:0];

  always_comb begin
    if (i_vdp_data_rd)
      o_cpu_data_in = i_vdp_data;
    else if (i_vdp_ctrl_rd)
      o_cpu_data_in = status;
    else if (io_rd && (port == `SMS_JOY_PORT_0 || port == `SMS_JOY_PORT_1 ||
                       port == `SMS_JOY_PORT_2))
      o_cpu_data_in = joy_data;
    else if (io_rd && port == `SMS_V_COUNTER_PORT)
      o_cpu_data_in = i_v_counter;
    else if (io_rd && port == `SMS_H_COUNTER_PORT)
      o_cpu_data_in = i_h_counter;
    else if (mem_rd && i_cpu_address[15:14] != 2'd3)
      o_cpu_data_in = i_bios_selected ? i_bios_data : i_rom_data;
    else
      o_cpu_data_in = i_ram_data;  // C000 and up
  end

endmodule

`default_nettype wire

// ==== hdl/sms_io_top.sv ====
`default_nettype none
`timescale 1ns/10ps
`include "sms_defines.svh"

module sms_io_top
  import sms_pkg::*;
(
  input  logic                        cpuClock,
  input  logic                        n_hard_reset,
  // Z80 bus
  input  logic                        i_n_rd,
  input  logic                        i_n_wr,
  input  logic                        i_n_mreq,
  input  logic                        i_n_iorq,
  input  logic [15:0]                 i_cpu_address,
  input  logic [7:0]                  i_cpu_data_out,
  output logic                        o_cpu_clock_enable,
  output logic [7:0]                  o_cpu_data_in,
  // Video renderer
  input  logic [7:0]                  i_vdp_data,
  input  logic [7:0]                  i_v_counter,
  input  logic [7:0]                  i_h_counter,
  input  logic                        i_interrupt_flag,
  input  logic                        i_sprite_collision,
  input  logic                        i_too_many_sprites,
  input  logic [4:0]                  i_sprite5,
  output logic [`SMS_VRAM_ADDR_W-1:0] o_vram_addr,
  output logic                        o_cram_selected,
  output logic                        o_vram_wr,
  output logic                        o_vram_rd,
  output logic [2:0]                  o_mode,
  output logic [`SMS_VRAM_ADDR_W-1:0] o_name_table_addr,
  output logic                        o_video_on,
  output logic                        o_vert_retrace_int,
  output vdp_ctrl_word_t              o_wr_data,  // VRAM and PSG write byte
  // Memories, joypad and sound
  input  logic [6:0]                  i_buttons,
  input  logic [7:0]                  i_ram_data,
  input  logic [7:0]                  i_bios_data,
  input  logic [7:0]                  i_rom_data,
  output logic [`SMS_ROM_ADDR_W-1:0]  o_rom_address,
  output logic                        o_bios_selected,
  output logic                        o_psg_wr
);

  logic       bus_edge;
  logic       vdp_ctrl_wr;
  logic       vdp_data_wr;
  logic       mem_ctrl_wr;
  logic       slot_wr;
  logic [1:0] slot_sel;
  logic       vdp_data_rd;
  logic       vdp_ctrl_rd;

  bus_cycle_decode u_decode (
    .cpuClock           (cpuClock),
    .n_hard_reset       (n_hard_reset),
    .i_n_rd             (i_n_rd),
    .i_n_wr             (i_n_wr),
    .i_n_mreq           (i_n_mreq),
    .i_n_iorq           (i_n_iorq),
    .i_cpu_address      (i_cpu_address),
    .i_cpu_data_out     (i_cpu_data_out),
    .o_cpu_clock_enable (o_cpu_clock_enable),
    .o_bus_edge         (bus_edge),
    .o_vdp_ctrl_wr      (vdp_ctrl_wr),
    .o_vdp_data_wr      (vdp_data_wr),
    .o_mem_ctrl_wr      (mem_ctrl_wr),
    .o_psg_wr           (o_psg_wr),
    .o_slot_wr          (slot_wr),
    .o_slot_sel         (slot_sel),
    .o_wr_data          (o_wr_data),
    .o_vdp_data_rd      (vdp_data_rd),
    .o_vdp_ctrl_rd      (vdp_ctrl_rd)
  );

  vdp_port u_vdp (
    .cpuClock           (cpuClock),
    .n_hard_reset       (n_hard_reset),
    .i_vdp_ctrl_wr      (vdp_ctrl_wr),
    .i_vdp_data_wr      (vdp_data_wr),
    .i_vdp_data_rd      (vdp_data_rd),
    .i_vdp_ctrl_rd      (vdp_ctrl_rd),
    .i_bus_edge         (bus_edge),
    .i_wr_data          (o_wr_data),
    .o_vram_addr        (o_vram_addr),
    .o_cram_selected    (o_cram_selected),
    .o_vram_wr          (o_vram_wr),
    .o_vram_rd          (o_vram_rd),
    .o_mode             (o_mode),
    .o_name_table_addr  (o_name_table_addr),
    .o_video_on         (o_video_on),
    .o_vert_retrace_int (o_vert_retrace_int)
  );

  memory_mapper u_mapper (
    .cpuClock        (cpuClock),
    .n_hard_reset    (n_hard_reset),
    .i_slot_wr       (slot_wr),
    .i_slot_sel      (slot_sel),
    .i_mem_ctrl_wr   (mem_ctrl_wr),
    .i_wr_data       (o_wr_data),
    .i_cpu_address   (i_cpu_address),
    .o_rom_address   (o_rom_address),
    .o_bios_selected (o_bios_selected)
  );

  cpu_read_mux u_read_mux (
    .cpuClock           (cpuClock),
    .n_hard_reset       (n_hard_reset),
    .i_n_rd             (i_n_rd),
    .i_n_mreq           (i_n_mreq),
    .i_n_iorq           (i_n_iorq),
    .i_cpu_address      (i_cpu_address),
    .i_bus_edge         (bus_edge),
    .i_vdp_ctrl_rd      (vdp_ctrl_rd),
    .i_vdp_data_rd      (vdp_data_rd),
    .i_bios_selected    (o_bios_selected),
    .i_vdp_data         (i_vdp_data),
    .i_v_counter        (i_v_counter),
    .i_h_counter        (i_h_counter),
    .i_buttons          (i_buttons),
    .i_interrupt_flag   (i_interrupt_flag),
    .i_sprite_collision (i_sprite_collision),
    .i_too_many_sprites (i_too_many_sprites),
    .i_sprite5          (i_sprite5),
    .i_ram_data         (i_ram_data),
    .i_bios_data        (i_bios_data),
    .i_rom_data         (i_rom_data),
    .o_cpu_data_in      (o_cpu_data_in)
  );

endmodule

`default_nettype wire

// ==== tb/tb_sms_io.sv ====
`default_nettype none
`timescale 1ns/10ps

module tb_sms_io;

  // Six tests of at most 25 bus cycles of 7 clocks, roughly doubled
  localparam int MAX_CYCLES = 2000;
  localparam logic [7:0] BIOS_BYTE = 8'hB1;
  localparam logic [7:0] ROM_BYTE  = 8'hC2;
  localparam logic [7:0] RAM_BYTE  = 8'hD3;
  localparam logic [7:0] VDP_BYTE  = 8'h6C;
  localparam logic [7:0] V_COUNT   = 8'h5A;
  localparam logic [7:0] H_COUNT   = 8'hA7;

  logic        cpuClock = 1'b0;
  logic        n_hard_reset;
  logic        i_n_rd;
  logic        i_n_wr;
  logic        i_n_mreq;
  logic        i_n_iorq;
  logic [15:0] i_cpu_address;
  logic [7:0]  i_cpu_data_out;
  logic [7:0]  i_vdp_data;
  logic [7:0]  i_v_counter;
  logic [7:0]  i_h_counter;
  logic        i_interrupt_flag;
  logic        i_sprite_collision;
  logic        i_too_many_sprites;
  logic [4:0]  i_sprite5;
  logic [6:0]  i_buttons;
  logic [7:0]  i_ram_data;
  logic [7:0]  i_bios_data;
  logic [7:0]  i_rom_data;
  logic        o_cpu_clock_enable;
  logic [7:0]  o_cpu_data_in;
  logic [13:0] o_vram_addr;
  logic        o_cram_selected;
  logic        o_vram_wr;
  logic        o_vram_rd;
  logic [2:0]  o_mode;
  logic [13:0] o_name_table_addr;
  logic        o_video_on;
  logic        o_vert_retrace_int;
  logic [7:0]  o_wr_data;
  logic [21:0] o_rom_address;
  logic        o_bios_selected;
  logic        o_psg_wr;

  logic en_q = 1'b0;  // Enable one clock ago
  int   errors = 0;
  int   tests_run = 0;
  int   cycle_count = 0;
  int   vram_wr_count = 0;
  int   vram_rd_count = 0;
  int   psg_wr_count = 0;

  sms_io_top UUT (
    .cpuClock           (cpuClock),
    .n_hard_reset       (n_hard_reset),
    .i_n_rd             (i_n_rd),
    .i_n_wr             (i_n_wr),
    .i_n_mreq           (i_n_mreq),
    .i_n_iorq           (i_n_iorq),
    .i_cpu_address      (i_cpu_address),
    .i_cpu_data_out     (i_cpu_data_out),
    .o_cpu_clock_enable (o_cpu_clock_enable),
    .o_cpu_data_in      (o_cpu_data_in),
    .i_vdp_data         (i_vdp_data),
    .i_v_counter        (i_v_counter),
    .i_h_counter        (i_h_counter),
    .i_interrupt_flag   (i_interrupt_flag),
    .i_sprite_collision (i_sprite_collision),
    .i_too_many_sprites (i_too_many_sprites),
    .i_sprite5          (i_sprite5),
    .o_vram_addr        (o_vram_addr),
    .o_cram_selected    (o_cram_selected),
    .o_vram_wr          (o_vram_wr),
    .o_vram_rd          (o_vram_rd),
    .o_mode             (o_mode),
    .o_name_table_addr  (o_name_table_addr),
    .o_video_on         (o_video_on),
    .o_vert_retrace_int (o_vert_retrace_int),
    .o_wr_data          (o_wr_data),
    .i_buttons          (i_buttons),
    .i_ram_data         (i_ram_data),
    .i_bios_data        (i_bios_data),
    .i_rom_data         (i_rom_data),
    .o_rom_address      (o_rom_address),
    .o_bios_selected    (o_bios_selected),
    .o_psg_wr           (o_psg_wr)
  );

  always #50 cpuClock = ~cpuClock;  // 100 ns period

  // ========================================
  // Monitors and timeout
  // ========================================
  always @(posedge cpuClock) begin
    en_q <= o_cpu_clock_enable;
    if (o_vram_wr)
      vram_wr_count++;
    if (o_vram_rd)
      vram_rd_count++;
    if (o_psg_wr)
      psg_wr_count++;
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // One Z80 access, released in the second bus edge cycle so it is taken once
  task automatic bus_cycle(input logic is_io, input logic is_wr, input logic [15:0] addr,
                           input logic [7:0] data, output logic [7:0] rd_data);
    int edges;
    begin
      edges = 0;
      rd_data = 8'h00;
      @(negedge cpuClock);
      i_cpu_address  = addr;
      i_cpu_data_out = data;
      i_n_iorq = !is_io;
      i_n_mreq = is_io;
      i_n_wr   = !is_wr;
      i_n_rd   = is_wr;
      while (edges < 2) begin
        if (o_cpu_clock_enable && !en_q) begin  // Bus edge cycle
          edges++;
          if (edges == 2)
            rd_data = o_cpu_data_in;  // Strobes settled since an earlier clock
        end
        if (edges < 2)
          @(negedge cpuClock);
      end
      i_n_iorq = 1'b1;
      i_n_mreq = 1'b1;
      i_n_wr   = 1'b1;
      i_n_rd   = 1'b1;
      @(negedge cpuClock);  // Let the end-of-read effects land
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    $display("Test %-14s %0d errors", name, errors - errs_before);
  endtask

  // ========================================
  // Directed tests
  // ========================================
  task automatic test_reset_defaults;
    int         errs;
    int         en_high;
    logic [7:0] rd;
    begin
      errs = errors;
      // Enable rises once per 7 clocks and stays high for 3 of them
      while (!(o_cpu_clock_enable && !en_q))
        @(negedge cpuClock);
      en_high = 0;
      for (int c = 0; c < 7; c++) begin
        if (o_cpu_clock_enable)
          en_high++;
        @(negedge cpuClock);
      end
      if (en_high != 3 || !(o_cpu_clock_enable && !en_q)) begin
        $display("Fail %0t: enable high %0d of 7 cycles, expected 3 and a new rise",
                 $time, en_high);
        errors++;
      end
      bus_cycle(1'b0, 1'b0, 16'h4000, 8'h00, rd);
      if (o_rom_address != 22'h004000) begin
        $display("Fail %0t: slot 1 address %h, expected 004000", $time, o_rom_address);
        errors++;
      end
      bus_cycle(1'b0, 1'b0, 16'h0000, 8'h00, rd);
      if (rd != BIOS_BYTE || !o_bios_selected) begin
        $display("Fail %0t: read at 0000 gave %h, BIOS select %b, expected %h and 1",
                 $time, rd, o_bios_selected, BIOS_BYTE);
        errors++;
      end
      bus_cycle(1'b0, 1'b0, 16'hC000, 8'h00, rd);
      if (rd != RAM_BYTE) begin
        $display("Fail %0t: read at C000 gave %h, expected RAM %h", $time, rd, RAM_BYTE);
        errors++;
      end
      if (o_mode != 3'd0 || o_vram_addr != 14'h0000) begin
        $display("Fail %0t: mode %0d VRAM address %h after reset", $time, o_mode, o_vram_addr);
        errors++;
      end
      if (o_video_on || o_vert_retrace_int) begin
        $display("Fail %0t: video on %b, frame interrupt %b after reset",
                 $time, o_video_on, o_vert_retrace_int);
        errors++;
      end
      end_test("reset", errs);
    end
  endtask

  task automatic test_mapper;
    int         errs;
    logic [7:0] rd;
    begin
      errs = errors;
      bus_cycle(1'b0, 1'b1, 16'hFFFE, 8'h05, rd);
      bus_cycle(1'b0, 1'b0, 16'h4123, 8'h00, rd);
      if (o_rom_address != 22'h014123) begin
        $display("Fail %0t: mapped address %h, expected 014123", $time, o_rom_address);
        errors++;
      end
      // Bit 3 set turns the BIOS off
      bus_cycle(1'b1, 1'b1, 16'h003E, 8'hAB, rd);
      bus_cycle(1'b0, 1'b0, 16'h0000, 8'h00, rd);
      if (rd != ROM_BYTE || o_bios_selected) begin
        $display("Fail %0t: read at 0000 gave %h, BIOS select %b, expected ROM %h and 0",
                 $time, rd, o_bios_selected, ROM_BYTE);
        errors++;
      end
      end_test("mapper", errs);
    end
  endtask

  task automatic test_vdp_registers;
    int         errs;
    logic [7:0] rd;
    begin
      errs = errors;
      bus_cycle(1'b1, 1'b1, 16'h00BF, 8'h04, rd);
      bus_cycle(1'b1, 1'b1, 16'h00BF, 8'h80, rd);  // R0
      if (o_mode != 3'd4) begin
        $display("Fail %0t: mode %0d, expected 4", $time, o_mode);
        errors++;
      end
      bus_cycle(1'b1, 1'b1, 16'h00BF, 8'h0E, rd);
      bus_cycle(1'b1, 1'b1, 16'h00BF, 8'h82, rd);  // R2
      if (o_name_table_addr != 14'h3800) begin
        $display("Fail %0t: name table %h, expected 3800", $time, o_name_table_addr);
        errors++;
      end
      // Display on and frame interrupt enable
      bus_cycle(1'b1, 1'b1, 16'h00BF, 8'h60, rd);
      bus_cycle(1'b1, 1'b1, 16'h00BF, 8'h81, rd);  // R1
      if (!o_video_on || !o_vert_retrace_int || o_mode != 3'd4) begin
        $display("Fail %0t: video on %b, frame interrupt %b, mode %0d, expected 1 1 4",
                 $time, o_video_on, o_vert_retrace_int, o_mode);
        errors++;
      end
      end_test("vdp_registers", errs);
    end
  endtask

  task automatic test_vram_address;
    int         errs;
    int         wr_before;
    int         rd_before;
    logic [7:0] rd;
    begin
      errs = errors;
      bus_cycle(1'b1, 1'b1, 16'h00BF, 8'h34, rd);
      bus_cycle(1'b1, 1'b1, 16'h00BF, 8'h52, rd);
      if (o_vram_addr != 14'h1234 || o_cram_selected) begin
        $display("Fail %0t: VRAM address %h, expected 1234", $time, o_vram_addr);
        errors++;
      end
      wr_before = vram_wr_count;
      bus_cycle(1'b1, 1'b1, 16'h00BE, 8'hAA, rd);
      bus_cycle(1'b1, 1'b1, 16'h00BE, 8'h55, rd);
      if (vram_wr_count - wr_before != 2 || o_vram_addr != 14'h1236) begin
        $display("Fail %0t: %0d VRAM writes, address %h, expected 2 and 1236",
                 $time, vram_wr_count - wr_before, o_vram_addr);
        errors++;
      end
      rd_before = vram_rd_count;
      bus_cycle(1'b1, 1'b0, 16'h00BE, 8'h00, rd);
      if (rd != VDP_BYTE || vram_rd_count - rd_before != 1 || o_vram_addr != 14'h1237) begin
        $display("Fail %0t: data read %h, address %h, expected %h and 1237",
                 $time, rd, o_vram_addr, VDP_BYTE);
        errors++;
      end
      bus_cycle(1'b1, 1'b1, 16'h00BF, 8'h05, rd);
      bus_cycle(1'b1, 1'b1, 16'h00BF, 8'hC0, rd);
      if (!o_cram_selected || o_vram_addr != 14'h0005) begin
        $display("Fail %0t: CRAM %b address %h, expected 1 and 0005",
                 $time, o_cram_selected, o_vram_addr);
        errors++;
      end
      end_test("vram_address", errs);
    end
  endtask

  task automatic test_status_flags;
    int         errs;
    logic [7:0] rd;
    begin
      errs = errors;
      @(negedge cpuClock);
      i_sprite_collision = 1'b1;
      @(negedge cpuClock);
      i_sprite_collision = 1'b0;
      bus_cycle(1'b1, 1'b0, 16'h00BF, 8'h00, rd);
      if (rd != {1'b0, 1'b0, 1'b1, 5'h1F}) begin
        $display("Fail %0t: status %h, expected collision set and 1F", $time, rd);
        errors++;
      end
      bus_cycle(1'b1, 1'b0, 16'h00BF, 8'h00, rd);
      if (rd != {3'b000, 5'h1F}) begin
        $display("Fail %0t: status %h, expected flags cleared", $time, rd);
        errors++;
      end
      end_test("status_flags", errs);
    end
  endtask

  task automatic test_ports;
    int         errs;
    int         psg_before;
    logic [7:0] rd;
    logic [7:0] joy_exp;
    begin
      errs = errors;
      i_buttons = 7'b0101010;
      joy_exp = 8'h2A;  // Buttons 2:1 give 10, buttons 6:3 give 1010
      for (int p = 0; p < 3; p++) begin
        bus_cycle(1'b1, 1'b0, 16'h00DC + 16'(p), 8'h00, rd);
        if (rd != joy_exp) begin
          $display("Fail %0t: joypad port %0d gave %h, expected %h", $time, p, rd, joy_exp);
          errors++;
        end
      end
      bus_cycle(1'b1, 1'b0, 16'h007E, 8'h00, rd);
      if (rd != V_COUNT) begin
        $display("Fail %0t: V counter %h, expected %h", $time, rd, V_COUNT);
        errors++;
      end
      bus_cycle(1'b1, 1'b0, 16'h007F, 8'h00, rd);
      if (rd != H_COUNT) begin
        $display("Fail %0t: H counter %h, expected %h", $time, rd, H_COUNT);
        errors++;
      end
      psg_before = psg_wr_count;
      bus_cycle(1'b1, 1'b1, 16'h007F, 8'h9F, rd);
      if (psg_wr_count - psg_before != 1 || o_wr_data != 8'h9F) begin
        $display("Fail %0t: %0d PSG strobes with byte %h, expected 1 and 9F",
                 $time, psg_wr_count - psg_before, o_wr_data);
        errors++;
      end
      end_test("ports", errs);
    end
  endtask

  initial begin
    n_hard_reset       = 1'b0;
    i_n_rd             = 1'b1;
    i_n_wr             = 1'b1;
    i_n_mreq           = 1'b1;
    i_n_iorq           = 1'b1;
    i_cpu_address      = 16'h0000;
    i_cpu_data_out     = 8'h00;
    i_vdp_data         = VDP_BYTE;
    i_v_counter        = V_COUNT;
    i_h_counter        = H_COUNT;
    i_interrupt_flag   = 1'b0;
    i_sprite_collision = 1'b0;
    i_too_many_sprites = 1'b0;
    i_sprite5          = 5'h0A;  // Hidden while too-many is low
    i_buttons          = 7'h7F;  // Nothing pressed
    i_ram_data         = RAM_BYTE;
    i_bios_data        = BIOS_BYTE;
    i_rom_data         = ROM_BYTE;
    repeat (4) @(posedge cpuClock);
    @(negedge cpuClock);
    n_hard_reset = 1'b1;

    test_reset_defaults();
    test_mapper();
    test_vdp_registers();
    test_vram_address();
    test_status_flags();
    test_ports();

    $display("Tests run %0d, errors %0d", tests_run, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hdl
hdl/sms_pkg.sv
hdl/bus_cycle_decode.sv
hdl/vdp_port.sv
hdl/memory_mapper.sv
hdl/cpu_read_mux.sv
hdl/sms_io_top.sv
tb/tb_sms_io.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --timing
TOP       := tb_sms_io
RTL_TOP   := sms_io_top
FILELIST  := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST) | grep -v '^+') hdl/sms_defines.svh
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
